// ==== filelist.f ====
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch.sv
hdl/exec_store_seq.sv
hdl/exec_control.sv
hdl/exec_top.sv
tb/exec_properties.sv
tb/exec_tb.sv

// ==== hdl/exec_alu.sv ====
//**********************************************************
// Execute stage ALU
//**********************************************************
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_alu (
  input  logic [`EXEC_OP_W-1:0]   op_i,
  input  logic [`EXEC_DATA_W-1:0] reg_a_i,
  input  logic [`EXEC_DATA_W-1:0] reg_b_i,
  input  logic [`EXEC_DATA_W-1:0] operand_i,
  input  exec_pkg::exec_imm_u     imm_i,
  output logic [`EXEC_DATA_W-1:0] result_o
);

  logic [`EXEC_DATA_W-1:0] incdec_amt;
  logic [`EXEC_DATA_W-1:0] sext_byte;
  logic [`EXEC_DATA_W-1:0] zext_byte;

  assign incdec_amt = {{(`EXEC_DATA_W-8){1'b0}}, imm_i.incdec.amount};
  assign sext_byte  = {{(`EXEC_DATA_W-8){reg_b_i[7]}}, reg_b_i[7:0]};
  assign zext_byte  = {{(`EXEC_DATA_W-8){1'b0}}, reg_b_i[7:0]};

  always_comb
  begin
    case (op_i)
      `EXEC_OP_ADD:
        result_o = reg_a_i + reg_b_i;
      `EXEC_OP_SUB:
        result_o = reg_a_i - reg_b_i;
      `EXEC_OP_AND:
        result_o = reg_a_i & reg_b_i;
      `EXEC_OP_OR:
        result_o = reg_a_i | reg_b_i;
      `EXEC_OP_XOR:
        result_o = reg_a_i ^ reg_b_i;
      `EXEC_OP_NOT:
        result_o = ~reg_b_i;
      `EXEC_OP_NEG:
        result_o = -reg_b_i;
      `EXEC_OP_ASHL:
        result_o = reg_a_i <<< reg_b_i;
      `EXEC_OP_ASHR:
        result_o = $signed(reg_a_i) >>> reg_b_i;
      `EXEC_OP_LSHR:
        result_o = reg_a_i >> reg_b_i;
      `EXEC_OP_MOV:
        result_o = reg_b_i;
      `EXEC_OP_INC:
        result_o = reg_a_i + incdec_amt;
      `EXEC_OP_DEC:
        result_o = reg_a_i - incdec_amt;
      `EXEC_OP_SEX_B:
        result_o = sext_byte;
      `EXEC_OP_ZEX_B:
        result_o = zext_byte;
      // Anything else passes the operand through, never written back
      default:
        result_o = operand_i;
    endcase
  end

endmodule

// ==== hdl/exec_branch.sv ====
//**********************************************************
// Compare flags and branch resolution
//**********************************************************
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_branch (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    accept_i,
  input  logic [`EXEC_OP_W-1:0]   op_i,
  input  logic [`EXEC_DATA_W-1:0] reg_a_i,
  input  logic [`EXEC_DATA_W-1:0] reg_b_i,
  input  logic [`EXEC_DATA_W-1:0] operand_i,
  input  exec_pkg::exec_imm_u     imm_i,
  input  logic [`EXEC_DATA_W-1:0] pc_i,
  output logic                    branch_flag_o,
  output logic [`EXEC_DATA_W-1:0] branch_target_o
);

  logic                    flag_eq;
  logic                    flag_lt;
  logic                    flag_gt;
  logic                    flag_ltu;
  logic                    flag_gtu;
  logic                    cond;
  logic                    branch_op;
  logic [`EXEC_DATA_W-1:0] off_ext;
  logic [`EXEC_DATA_W-1:0] pc_rel;

  // Halfword offset, sign extended
  assign off_ext = {{(`EXEC_DATA_W-`EXEC_IMM_W-1){imm_i.branch_off[`EXEC_IMM_W-1]}},
                    imm_i.branch_off, 1'b0};
  assign pc_rel  = pc_i + off_ext + `EXEC_DATA_W'd2;

  always_comb
  begin
    branch_op = 1'b1;
    case (op_i)
      `EXEC_OP_BEQ:  cond = flag_eq;
      `EXEC_OP_BNE:  cond = ~flag_eq;
      `EXEC_OP_BLT:  cond = flag_lt;
      `EXEC_OP_BGT:  cond = flag_gt;
      `EXEC_OP_BLTU: cond = flag_ltu;
      `EXEC_OP_BGTU: cond = flag_gtu;
      `EXEC_OP_BLE:  cond = flag_eq | flag_lt;
      `EXEC_OP_BGE:  cond = flag_eq | flag_gt;
      `EXEC_OP_BLEU: cond = flag_eq | flag_ltu;
      `EXEC_OP_BGEU: cond = flag_eq | flag_gtu;
      `EXEC_OP_JMPA: cond = 1'b1;
      default:
      begin
        cond      = 1'b0;
        branch_op = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      flag_eq       <= 1'b0;
      flag_lt       <= 1'b0;
      flag_gt       <= 1'b0;
      flag_ltu      <= 1'b0;
      flag_gtu      <= 1'b0;
      branch_flag_o <= 1'b0;
    end
    else
    begin
      branch_flag_o <= accept_i & cond;
      if (accept_i && op_i == `EXEC_OP_CMP)
      begin
        flag_eq  <= reg_a_i == reg_b_i;
        flag_lt  <= $signed(reg_a_i) < $signed(reg_b_i);
        flag_gt  <= $signed(reg_a_i) > $signed(reg_b_i);
        flag_ltu <= reg_a_i < reg_b_i;
        flag_gtu <= reg_a_i > reg_b_i;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_i && branch_op)
      branch_target_o <= (op_i == `EXEC_OP_JMPA) ? operand_i : pc_rel;
  end

endmodule

// ==== hdl/exec_config.svh ====
//**********************************************************
// Execute stage widths and encodings
//**********************************************************
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

`define EXEC_DATA_W 32
`define EXEC_BUS_W 16
`define EXEC_IDX_W 4
`define EXEC_OP_W 7
`define EXEC_IMM_W 10

// Register arithmetic and logic
`define EXEC_OP_MOV 7'h02
`define EXEC_OP_ADD 7'h05
`define EXEC_OP_SEX_B 7'h10
`define EXEC_OP_ZEX_B 7'h12
`define EXEC_OP_AND 7'h26
`define EXEC_OP_LSHR 7'h27
`define EXEC_OP_ASHL 7'h28
`define EXEC_OP_SUB 7'h29
`define EXEC_OP_NEG 7'h2a
`define EXEC_OP_OR 7'h2b
`define EXEC_OP_NOT 7'h2c
`define EXEC_OP_ASHR 7'h2d
`define EXEC_OP_XOR 7'h2e
`define EXEC_OP_INC 7'h40
`define EXEC_OP_DEC 7'h41

`define EXEC_OP_CMP 7'h0e

// Branches
`define EXEC_OP_JMPA 7'h1a
`define EXEC_OP_BEQ 7'h60
`define EXEC_OP_BNE 7'h61
`define EXEC_OP_BLT 7'h62
`define EXEC_OP_BGT 7'h63
`define EXEC_OP_BLTU 7'h64
`define EXEC_OP_BGTU 7'h65
`define EXEC_OP_BGE 7'h66
`define EXEC_OP_BLE 7'h67
`define EXEC_OP_BGEU 7'h68
`define EXEC_OP_BLEU 7'h69

// Register-indirect stores
`define EXEC_OP_ST_L 7'h0b
`define EXEC_OP_ST_B 7'h1e
`define EXEC_OP_ST_S 7'h23

// Bus byte selects
`define EXEC_SEL_BYTE 2'b01
`define EXEC_SEL_HALF 2'b11

`endif

// ==== hdl/exec_control.sv ====
//**********************************************************
// Execute stage acceptance and write-back
//**********************************************************
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_control (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  logic                    stall_i,
  input  logic                    flush_i,
  input  logic [`EXEC_OP_W-1:0]   op_i,
  input  logic [`EXEC_IDX_W-1:0]  dest_idx_i,
  input  logic [`EXEC_DATA_W-1:0] alu_result_i,
  input  logic                    branch_flag_i,
  input  logic                    store_busy_i,
  output logic                    accept_o,
  output logic [`EXEC_DATA_W-1:0] result_o,
  output logic [`EXEC_IDX_W-1:0]  result_idx_o,
  output logic                    result_we_o
);

  logic shadow_q;
  logic shadow;
  logic is_wb;

  // Shadow covers the first unstalled cycle after a taken branch
  assign shadow   = branch_flag_i | shadow_q;
  assign accept_o = valid_i & ~stall_i & ~flush_i & ~store_busy_i & ~shadow;

  always_comb
  begin
    case (op_i)
      `EXEC_OP_ADD,
      `EXEC_OP_SUB,
      `EXEC_OP_AND,
      `EXEC_OP_OR,
      `EXEC_OP_XOR,
      `EXEC_OP_NOT,
      `EXEC_OP_NEG,
      `EXEC_OP_ASHL,
      `EXEC_OP_ASHR,
      `EXEC_OP_LSHR,
      `EXEC_OP_MOV,
      `EXEC_OP_INC,
      `EXEC_OP_DEC,
      `EXEC_OP_SEX_B,
      `EXEC_OP_ZEX_B:
        is_wb = 1'b1;
      default:
        is_wb = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      shadow_q    <= 1'b0;
      result_we_o <= 1'b0;
    end
    else
    begin
      shadow_q    <= shadow & stall_i;
      result_we_o <= accept_o & is_wb;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_o && is_wb)
    begin
      result_o     <= alu_result_i;
      result_idx_o <= dest_idx_i;
    end
  end

endmodule

// ==== hdl/exec_pkg.sv ====
//**********************************************************
// Execute stage types
//**********************************************************
`include "exec_config.svh"

package exec_pkg;

  // Immediate field, read as branch offset or inc/dec amount
  typedef union packed {
    logic signed [`EXEC_IMM_W-1:0] branch_off;
    struct packed {
      logic [`EXEC_IMM_W-9:0] unused;
      logic [7:0]             amount;
    } incdec;
  } exec_imm_u;

endpackage

// ==== hdl/exec_store_seq.sv ====
//**********************************************************
// Data bus store sequencer
//**********************************************************
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_store_seq (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    start_i,
  input  logic [`EXEC_OP_W-1:0]   op_i,
  input  logic [`EXEC_DATA_W-1:0] reg_a_i,
  input  logic [`EXEC_DATA_W-1:0] reg_b_i,
  input  logic                    dmem_ack_i,
  output logic                    dmem_cyc_o,
  output logic                    dmem_stb_o,
  output logic                    dmem_we_o,
  output logic [1:0]              dmem_sel_o,
  output logic [`EXEC_DATA_W-1:0] dmem_addr_o,
  output logic [`EXEC_BUS_W-1:0]  dmem_data_o,
  output logic                    busy_o
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_BEAT1 = 2'd1;
  localparam logic [1:0] ST_BEAT2 = 2'd2;

  logic [1:0]              state;
  logic                    long_q;
  logic                    is_store;
  logic                    load;
  logic [`EXEC_DATA_W-1:0] next_addr;
  logic [`EXEC_BUS_W-1:0]  next_data;

  assign is_store = (op_i == `EXEC_OP_ST_B) || (op_i == `EXEC_OP_ST_S) ||
                    (op_i == `EXEC_OP_ST_L);
  assign load     = (state == ST_IDLE) && start_i && is_store;

  // A beat is on the bus in every non-idle state
  assign busy_o     = state != ST_IDLE;
  assign dmem_cyc_o = busy_o;
  assign dmem_stb_o = busy_o;
  assign dmem_we_o  = busy_o;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state  <= ST_IDLE;
      long_q <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (load)
          begin
            state  <= ST_BEAT1;
            long_q <= op_i == `EXEC_OP_ST_L;
          end
        end
        ST_BEAT1:
        begin
          if (dmem_ack_i)
            state <= long_q ? ST_BEAT2 : ST_IDLE;
        end
        ST_BEAT2:
        begin
          if (dmem_ack_i)
            state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      dmem_addr_o <= reg_a_i;
      next_addr   <= reg_a_i + `EXEC_DATA_W'd2;
      next_data   <= reg_b_i[`EXEC_BUS_W-1:0];
      case (op_i)
        `EXEC_OP_ST_B:
        begin
          dmem_data_o <= {{(`EXEC_BUS_W-8){1'b0}}, reg_b_i[7:0]};
          dmem_sel_o  <= `EXEC_SEL_BYTE;
        end
        `EXEC_OP_ST_S:
        begin
          dmem_data_o <= reg_b_i[`EXEC_BUS_W-1:0];
          dmem_sel_o  <= `EXEC_SEL_HALF;
        end
        // Long store, high half goes first
        default:
        begin
          dmem_data_o <= reg_b_i[`EXEC_DATA_W-1:`EXEC_BUS_W];
          dmem_sel_o  <= `EXEC_SEL_HALF;
        end
      endcase
    end
    else if (state == ST_BEAT1 && dmem_ack_i && long_q)
    begin
      dmem_addr_o <= next_addr;
      dmem_data_o <= next_data;
    end
  end

endmodule

// ==== hdl/exec_top.sv ====
//**********************************************************
// Integer execute stage
//**********************************************************
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  logic [`EXEC_OP_W-1:0]   op_i,
  input  logic [`EXEC_DATA_W-1:0] reg_a_i,
  input  logic [`EXEC_DATA_W-1:0] reg_b_i,
  input  logic [`EXEC_DATA_W-1:0] operand_i,
  input  exec_pkg::exec_imm_u     imm_i,
  input  logic [`EXEC_DATA_W-1:0] pc_i,
  input  logic [`EXEC_IDX_W-1:0]  dest_idx_i,
  input  logic                    stall_i,
  input  logic                    flush_i,
  output logic [`EXEC_DATA_W-1:0] result_o,
  output logic [`EXEC_IDX_W-1:0]  result_idx_o,
  output logic                    result_we_o,
  output logic                    branch_flag_o,
  output logic [`EXEC_DATA_W-1:0] branch_target_o,
  output logic                    dmem_cyc_o,
  output logic                    dmem_stb_o,
  output logic                    dmem_we_o,
  output logic [1:0]              dmem_sel_o,
  output logic [`EXEC_DATA_W-1:0] dmem_addr_o,
  output logic [`EXEC_BUS_W-1:0]  dmem_data_o,
  input  logic                    dmem_ack_i,
  output logic                    busy_o
);

  logic                    accept;
  logic [`EXEC_DATA_W-1:0] alu_result;

  exec_control u_control (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (valid_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .op_i         (op_i),
    .dest_idx_i   (dest_idx_i),
    .alu_result_i (alu_result),
    .branch_flag_i(branch_flag_o),
    .store_busy_i (busy_o),
    .accept_o     (accept),
    .result_o     (result_o),
    .result_idx_o (result_idx_o),
    .result_we_o  (result_we_o)
  );

  exec_alu u_alu (
    .op_i     (op_i),
    .reg_a_i  (reg_a_i),
    .reg_b_i  (reg_b_i),
    .operand_i(operand_i),
    .imm_i    (imm_i),
    .result_o (alu_result)
  );

  exec_branch u_branch (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .accept_i       (accept),
    .op_i           (op_i),
    .reg_a_i        (reg_a_i),
    .reg_b_i        (reg_b_i),
    .operand_i      (operand_i),
    .imm_i          (imm_i),
    .pc_i           (pc_i),
    .branch_flag_o  (branch_flag_o),
    .branch_target_o(branch_target_o)
  );

  exec_store_seq u_store (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_i    (accept),
    .op_i       (op_i),
    .reg_a_i    (reg_a_i),
    .reg_b_i    (reg_b_i),
    .dmem_ack_i (dmem_ack_i),
    .dmem_cyc_o (dmem_cyc_o),
    .dmem_stb_o (dmem_stb_o),
    .dmem_we_o  (dmem_we_o),
    .dmem_sel_o (dmem_sel_o),
    .dmem_addr_o(dmem_addr_o),
    .dmem_data_o(dmem_data_o),
    .busy_o     (busy_o)
  );

endmodule

// ==== tb/exec_properties.sv ====
//**********************************************************
// Execute stage bus and pulse checks
//**********************************************************
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_properties (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    valid_i,
  input logic                    stall_i,
  input logic                    flush_i,
  input logic                    result_we_i,
  input logic                    branch_flag_i,
  input logic                    dmem_cyc_i,
  input logic                    dmem_stb_i,
  input logic                    dmem_ack_i,
  input logic [1:0]              dmem_sel_i,
  input logic [`EXEC_DATA_W-1:0] dmem_addr_i,
  input logic [`EXEC_BUS_W-1:0]  dmem_data_i
);

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_stb_i |-> dmem_cyc_i)
  else
    $error("Bus strobe raised outside a bus cycle");

  // Beat held until acknowledged
  beat_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_stb_i && !dmem_ack_i |=> dmem_stb_i && $stable(dmem_addr_i) &&
      $stable(dmem_data_i) && $stable(dmem_sel_i))
  else
    $error("Bus beat changed before its acknowledge");

  // Write enable only extends for a new unblocked instruction
  we_single: assert property (@(posedge clk_i) disable iff (rst_i)
    result_we_i && (!valid_i || stall_i || flush_i) |=> !result_we_i)
  else
    $error("Write enable held without a new instruction");

  branch_single: assert property (@(posedge clk_i) disable iff (rst_i)
    branch_flag_i |=> !branch_flag_i)
  else
    $error("Branch flag high for two cycles in a row");

endmodule

bind exec_top exec_properties u_props (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .valid_i      (valid_i),
  .stall_i      (stall_i),
  .flush_i      (flush_i),
  .result_we_i  (result_we_o),
  .branch_flag_i(branch_flag_o),
  .dmem_cyc_i   (dmem_cyc_o),
  .dmem_stb_i   (dmem_stb_o),
  .dmem_ack_i   (dmem_ack_i),
  .dmem_sel_i   (dmem_sel_o),
  .dmem_addr_i  (dmem_addr_o),
  .dmem_data_i  (dmem_data_o)
);

// ==== tb/exec_tb.sv ====
//**********************************************************
// Execute stage testbench
//**********************************************************
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_tb;

  localparam int NUM_INSTR   = 400;
  localparam int CYCLE_LIMIT = NUM_INSTR * 8;

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  logic                    valid_i;
  logic [`EXEC_OP_W-1:0]   op_i;
  logic [`EXEC_DATA_W-1:0] reg_a_i;
  logic [`EXEC_DATA_W-1:0] reg_b_i;
  logic [`EXEC_DATA_W-1:0] operand_i;
  exec_pkg::exec_imm_u     imm_i;
  logic [`EXEC_DATA_W-1:0] pc_i;
  logic [`EXEC_IDX_W-1:0]  dest_idx_i;
  logic                    stall_i;
  logic                    flush_i;
  logic                    dmem_ack_i;
  logic [`EXEC_DATA_W-1:0] result_o;
  logic [`EXEC_IDX_W-1:0]  result_idx_o;
  logic                    result_we_o;
  logic                    branch_flag_o;
  logic [`EXEC_DATA_W-1:0] branch_target_o;
  logic                    dmem_cyc_o;
  logic                    dmem_stb_o;
  logic                    dmem_we_o;
  logic [1:0]              dmem_sel_o;
  logic [`EXEC_DATA_W-1:0] dmem_addr_o;
  logic [`EXEC_BUS_W-1:0]  dmem_data_o;
  logic                    busy_o;

  // Model state, flags ordered eq, lt, gt, ltu, gtu
  logic [4:0]              ref_flags;
  logic                    ref_shadow;
  logic                    ref_busy;
  int                      ref_beats;
  logic                    exp_we;
  logic [`EXEC_DATA_W-1:0] exp_result;
  logic [`EXEC_IDX_W-1:0]  exp_idx;
  logic                    exp_branch;
  logic [`EXEC_DATA_W-1:0] exp_target;

  // Beats packed as {sel, addr, data}
  logic [49:0]             exp_beats[$];
  logic [49:0]             beat_log[$];
  logic [`EXEC_OP_W-1:0]   op_table[0:29];
  int                      cycle = 0;
  int                      ack_delay;
  logic                    ack_waiting;
  int unsigned             seed;

  exec_top DUT (.*);

  always #2 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] want,
                             input logic [31:0] got);
    assert (got === want)
    else
      fail_run($sformatf("Fail at %0t ns: %s expected %0h, got %0h", $time, name, want, got));
  endtask

  function automatic void exec_ref(
    input  logic [`EXEC_OP_W-1:0]   op,
    input  logic [`EXEC_DATA_W-1:0] a,
    input  logic [`EXEC_DATA_W-1:0] b,
    input  logic [`EXEC_DATA_W-1:0] opnd,
    input  logic [`EXEC_IMM_W-1:0]  imm,
    input  logic [`EXEC_DATA_W-1:0] pc,
    input  logic [4:0]              flags_in,
    output logic                    wb,
    output logic [`EXEC_DATA_W-1:0] res,
    output logic                    taken,
    output logic [`EXEC_DATA_W-1:0] target,
    output logic [4:0]              flags_out
  );
    logic signed [`EXEC_DATA_W-1:0] sa;
    logic [`EXEC_DATA_W-1:0]        amt;
    logic [`EXEC_DATA_W-1:0]        off;
    sa  = a;
    // Low 8 bits are the inc/dec amount, all 10 the halfword offset
    amt = {24'd0, imm[7:0]};
    off = {{21{imm[9]}}, imm, 1'b0};
    wb        = 1'b1;
    res       = '0;
    taken     = 1'b0;
    target    = pc + 32'd2 + off;
    flags_out = flags_in;
    case (op)
      `EXEC_OP_ADD:   res = a + b;
      `EXEC_OP_SUB:   res = a - b;
      `EXEC_OP_AND:   res = a & b;
      `EXEC_OP_OR:    res = a | b;
      `EXEC_OP_XOR:   res = a ^ b;
      `EXEC_OP_NOT:   res = ~b;
      `EXEC_OP_NEG:   res = 32'd0 - b;
      `EXEC_OP_ASHL:  res = a << b;
      `EXEC_OP_ASHR:  res = sa >>> b;
      `EXEC_OP_LSHR:  res = a >> b;
      `EXEC_OP_MOV:   res = b;
      `EXEC_OP_INC:   res = a + amt;
      `EXEC_OP_DEC:   res = a - amt;
      `EXEC_OP_SEX_B: res = {{24{b[7]}}, b[7:0]};
      `EXEC_OP_ZEX_B: res = {24'd0, b[7:0]};
      default:        wb = 1'b0;
    endcase
    case (op)
      `EXEC_OP_CMP:
        flags_out = {a == b, $signed(a) < $signed(b), $signed(a) > $signed(b), a < b, a > b};
      `EXEC_OP_BEQ:  taken = flags_in[4];
      `EXEC_OP_BNE:  taken = !flags_in[4];
      `EXEC_OP_BLT:  taken = flags_in[3];
      `EXEC_OP_BGT:  taken = flags_in[2];
      `EXEC_OP_BLTU: taken = flags_in[1];
      `EXEC_OP_BGTU: taken = flags_in[0];
      `EXEC_OP_BLE:  taken = flags_in[4] | flags_in[3];
      `EXEC_OP_BGE:  taken = flags_in[4] | flags_in[2];
      `EXEC_OP_BLEU: taken = flags_in[4] | flags_in[1];
      `EXEC_OP_BGEU: taken = flags_in[4] | flags_in[0];
      `EXEC_OP_JMPA:
      begin
        taken  = 1'b1;
        target = opnd;
      end
      default:
        taken = 1'b0;
    endcase
  endfunction

  // Cycle model of acceptance, shadow and store progress
  always @(posedge clk_i or posedge rst_i)
  begin : predict
    logic                    acc;
    logic                    wb;
    logic                    taken;
    logic [`EXEC_DATA_W-1:0] res;
    logic [`EXEC_DATA_W-1:0] target;
    logic [4:0]              flags;
    if (rst_i)
    begin
      ref_flags  = '0;
      ref_shadow = 1'b0;
      ref_busy   = 1'b0;
      ref_beats  = 0;
      exp_we     = 1'b0;
      exp_branch = 1'b0;
    end
    else
    begin
      acc = valid_i && !stall_i && !flush_i && !ref_busy && !ref_shadow;
      if (ref_shadow && !stall_i)
        ref_shadow = 1'b0;
      if (ref_busy && dmem_ack_i)
      begin
        ref_beats = ref_beats - 1;
        ref_busy  = ref_beats > 0;
      end
      exp_we     = 1'b0;
      exp_branch = 1'b0;
      if (acc)
      begin
        exec_ref(op_i, reg_a_i, reg_b_i, operand_i, imm_i, pc_i, ref_flags,
                 wb, res, taken, target, flags);
        exp_we     = wb;
        exp_result = res;
        exp_idx    = dest_idx_i;
        exp_branch = taken;
        exp_target = target;
        ref_shadow = taken;
        ref_flags  = flags;
        case (op_i)
          `EXEC_OP_ST_B:
          begin
            exp_beats.push_back({`EXEC_SEL_BYTE, reg_a_i, 8'h00, reg_b_i[7:0]});
            ref_beats = 1;
          end
          `EXEC_OP_ST_S:
          begin
            exp_beats.push_back({`EXEC_SEL_HALF, reg_a_i, reg_b_i[15:0]});
            ref_beats = 1;
          end
          `EXEC_OP_ST_L:
          begin
            exp_beats.push_back({`EXEC_SEL_HALF, reg_a_i, reg_b_i[31:16]});
            exp_beats.push_back({`EXEC_SEL_HALF, reg_a_i + 32'd2, reg_b_i[15:0]});
            ref_beats = 2;
          end
          default:
            ref_beats = 0;
        endcase
        ref_busy = ref_beats > 0;
      end
    end
  end

  // Memory side, acks after 0 to 3 cycles
  always @(negedge clk_i)
  begin
    if (rst_i || dmem_ack_i)
    begin
      dmem_ack_i <= 1'b0;
      if (rst_i)
        ack_waiting = 1'b0;
    end
    else if (dmem_stb_o)
    begin
      if (!ack_waiting)
      begin
        ack_delay   = $urandom % 4;
        ack_waiting = 1'b1;
      end
      if (ack_delay == 0)
      begin
        dmem_ack_i <= 1'b1;
        ack_waiting = 1'b0;
        beat_log.push_back({dmem_sel_o, dmem_addr_o, dmem_data_o});
      end
      else
        ack_delay = ack_delay - 1;
    end
  end

  always @(negedge clk_i)
  begin : compare
    logic [49:0] want;
    logic [49:0] got;
    if (!rst_i)
    begin
      check_value("result_we_o", exp_we, result_we_o);
      if (exp_we)
      begin
        check_value("result_o", exp_result, result_o);
        check_value("result_idx_o", exp_idx, result_idx_o);
      end
      check_value("branch_flag_o", exp_branch, branch_flag_o);
      if (exp_branch)
        check_value("branch_target_o", exp_target, branch_target_o);
      check_value("busy_o", ref_busy, busy_o);
      check_value("dmem_cyc_o", ref_busy, dmem_cyc_o);
      check_value("dmem_stb_o", ref_busy, dmem_stb_o);
      check_value("dmem_we_o", ref_busy, dmem_we_o);
      while (beat_log.size() > 0)
      begin
        got = beat_log.pop_front();
        assert (exp_beats.size() > 0)
        else
          fail_run("A bus beat appeared with no store outstanding");
        want = exp_beats.pop_front();
        check_value("dmem_sel_o", want[49:48], got[49:48]);
        check_value("dmem_addr_o", want[47:16], got[47:16]);
        check_value("dmem_data_o", want[15:0], got[15:0]);
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT)
      fail_run($sformatf("Timeout: run still going after %0d cycles", CYCLE_LIMIT));
  end

  task automatic present(input logic [`EXEC_OP_W-1:0] op, input logic [31:0] a,
                         input logic [31:0] b, input logic stall, input logic flush);
    logic [31:0] r;
    @(negedge clk_i);
    r          = $urandom;
    valid_i    = 1'b1;
    op_i       = op;
    reg_a_i    = a;
    reg_b_i    = b;
    operand_i  = $urandom;
    imm_i      = r[9:0];
    dest_idx_i = r[15:12];
    pc_i       = {r[31:16], 16'h0} | {r[15:1], 1'b0};
    stall_i    = stall;
    flush_i    = flush;
  endtask

  task automatic idle();
    @(negedge clk_i);
    valid_i = 1'b0;
    stall_i = 1'b0;
    flush_i = 1'b0;
  endtask

  task automatic random_instr();
    logic [31:0] b;
    b = $urandom;
    // Small counts keep shifts interesting
    if ($urandom % 2)
      b = b % 40;
    if ($urandom % 8 == 0)
      idle();
    else
      present(op_table[$urandom % 30], $urandom, b, $urandom % 8 == 0, $urandom % 16 == 0);
  endtask

  task automatic cmp_then_branch(input logic [`EXEC_OP_W-1:0] br_op, input logic [31:0] a,
                                 input logic [31:0] b);
    present(`EXEC_OP_CMP, a, b, 1'b0, 1'b0);
    present(br_op, $urandom, $urandom, 1'b0, 1'b0);
    idle();
  endtask

  initial
  begin
    logic [31:0] a;
    seed = 68;
    void'($urandom(seed));
    op_table = '{`EXEC_OP_ADD, `EXEC_OP_SUB, `EXEC_OP_AND, `EXEC_OP_OR, `EXEC_OP_XOR,
                 `EXEC_OP_NOT, `EXEC_OP_NEG, `EXEC_OP_ASHL, `EXEC_OP_ASHR, `EXEC_OP_LSHR,
                 `EXEC_OP_MOV, `EXEC_OP_INC, `EXEC_OP_DEC, `EXEC_OP_SEX_B, `EXEC_OP_ZEX_B,
                 `EXEC_OP_CMP, `EXEC_OP_BEQ, `EXEC_OP_BNE, `EXEC_OP_BLT, `EXEC_OP_BGT,
                 `EXEC_OP_BLTU, `EXEC_OP_BGTU, `EXEC_OP_BLE, `EXEC_OP_BGE, `EXEC_OP_BLEU,
                 `EXEC_OP_BGEU, `EXEC_OP_JMPA, `EXEC_OP_ST_B, `EXEC_OP_ST_S, `EXEC_OP_ST_L};
    rst_i      = 1'b1;
    valid_i    = 1'b0;
    op_i       = '0;
    reg_a_i    = '0;
    reg_b_i    = '0;
    operand_i  = '0;
    imm_i      = '0;
    pc_i       = '0;
    dest_idx_i = '0;
    stall_i    = 1'b0;
    flush_i    = 1'b0;
    dmem_ack_i = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    // Outputs checked quiet before any instruction
    repeat (3) idle();
    for (int i = 0; i < NUM_INSTR - 80; i++)
      random_instr();
    idle();
    while (ref_busy)
      idle();
    // Each conditional branch against equal, sign-differing and random compares
    for (int i = 0; i < 10; i++)
    begin
      a = $urandom;
      cmp_then_branch(op_table[16 + i], a, a);
      cmp_then_branch(op_table[16 + i], 32'h8000_0000, 32'h0000_0001);
      cmp_then_branch(op_table[16 + i], 32'h0000_0001, 32'hffff_ffff);
      cmp_then_branch(op_table[16 + i], $urandom, $urandom);
    end
    while (ref_busy)
      idle();
    repeat (4) idle();
    assert (exp_beats.size() == 0 && beat_log.size() == 0)
    else
      fail_run("Store beats were expected but never matched on the bus");
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
